// ==== verilog/hdmi_cfg.svh ====
`ifndef HDMI_CFG_SVH
`define HDMI_CFG_SVH

// 640x480 frame, 800x525 total
`define H_TOTAL 800
`define H_ACTIVE 640
`define V_TOTAL 525
`define V_ACTIVE 480

// data island slot, in horizontal blanking
`define PKT_POS 656

// audio path
`define AUDIO_BITS 16
`define FIFO_DEPTH 128

// pixel clocks per sample, about 36 kHz at 25.2 MHz
`define SAMPLE_DIV 700

`endif

// ==== verilog/hdmi_pkg.sv ====
`default_nettype none

`include "hdmi_cfg.svh"

package hdmi_pkg;

    // data island packet header byte 0
    typedef enum logic [7:0] {
        pkt_null      = 8'h00,
        pkt_acr       = 8'h01,
        pkt_audio     = 8'h02,
        pkt_infoframe = 8'h84
    } packet_type_e;

    typedef struct packed {
        logic [9:0] cx;
        logic [9:0] cy;
        logic       active; // inside 640x480
    } screen_pos_t;

    typedef struct packed {
        logic                   valid;
        packet_type_e           ptype;
        logic [`AUDIO_BITS-1:0] sample; // only meaningful for pkt_audio
    } packet_out_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

`default_nettype wire

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_cfg.svh"

module video_timing (
    input  wire                   clk_pixel,
    input  wire                   rst_n,
    output hdmi_pkg::screen_pos_t pos,
    output logic                  packet_enable
);

    logic [9:0] cx;
    logic [9:0] cy;
    logic       active;
    logic       line_end;
    logic       frame_end;

    assign line_end  = (cx == 10'(`H_TOTAL - 1));
    assign frame_end = (cy == 10'(`V_TOTAL - 1));

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            cx <= '0;
            cy <= '0;
        end
        else if (line_end)
        begin
            cx <= '0;
            cy <= frame_end ? 10'd0 : cy + 10'd1;
        end
        else
        begin
            cx <= cx + 10'd1;
        end
    end

    assign active = (cx < 10'(`H_ACTIVE)) && (cy < 10'(`V_ACTIVE));

    // position is the counter state itself, no extra stage
    assign pos.cx     = cx;
    assign pos.cy     = cy;
    assign pos.active = active;

    // one island opportunity per line
    assign packet_enable = (cx == 10'(`PKT_POS));

    a_pkt_in_blanking: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        packet_enable |-> !pos.active);

endmodule

`default_nettype wire

// ==== verilog/sawtooth.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_cfg.svh"

module sawtooth (
    input  wire                    clk_pixel,
    input  wire                    rst_n,
    input  wire  [`AUDIO_BITS-1:0] step,
    output logic                   sample_strobe,
    output logic [`AUDIO_BITS-1:0] level
);

    logic [9:0] div_cnt;

    // sample rate divider
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            div_cnt       <= '0;
            sample_strobe <= 1'b0;
        end
        else if (div_cnt == 10'(`SAMPLE_DIV - 1))
        begin
            div_cnt       <= '0;
            sample_strobe <= 1'b1;
        end
        else
        begin
            div_cnt       <= div_cnt + 10'd1;
            sample_strobe <= 1'b0;
        end
    end

    // ramp, wraps naturally
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
            level <= '0;
        else if (sample_strobe)
            level <= level + step; // new value after the pulse
    end

endmodule

`default_nettype wire

// ==== verilog/audio_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_fifo #(
    parameter int DEPTH = 128,
    parameter int WIDTH = 16
) (
    input  wire                        clk_pixel,
    input  wire                        rst_n,
    input  wire                        push,
    input  wire  [WIDTH-1:0]           wdata,
    input  wire                        pop,
    output logic [WIDTH-1:0]           rdata,
    output logic [$clog2(DEPTH+1)-1:0] count,
    output logic                       overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok = push && (count < DEPTH); // full drops the sample
    assign rd_ok = pop && (count != '0);

    // fall-through head
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk_pixel)
    begin
        if (wr_ok)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            // explicit wrap so DEPTH need not be a power of two
            if (wr_ok)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (push && !wr_ok)
                overflow <= 1'b1; // sticky
        end
    end

    // the scheduler must only pop when it saw data
    a_no_pop_empty: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        pop |-> count != '0);

endmodule

`default_nettype wire

// ==== verilog/packet_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_cfg.svh"

module packet_scheduler (
    input  wire                                clk_pixel,
    input  wire                                rst_n,
    input  wire hdmi_pkg::screen_pos_t         pos,
    input  wire                                packet_enable,
    input  wire  [`AUDIO_BITS-1:0]             fifo_data,
    input  wire  [$clog2(`FIFO_DEPTH+1)-1:0]   fifo_count,
    output logic                               fifo_pop,
    output hdmi_pkg::packet_out_t              packet_out
);

    import hdmi_pkg::*;

    logic                   acr_sent;
    logic                   infoframe_sent;
    logic                   frame_start;
    packet_type_e           next_type;
    logic                   out_valid;
    packet_type_e           out_type;
    logic [`AUDIO_BITS-1:0] out_sample;

    assign frame_start = (pos.cx == 10'd0) && (pos.cy == 10'd0);

    // ACR first, then InfoFrame, then audio when buffered
    always_comb
    begin
        if (!acr_sent)
            next_type = pkt_acr;
        else if (!infoframe_sent)
            next_type = pkt_infoframe;
        else if (fifo_count != '0)
            next_type = pkt_audio;
        else
            next_type = pkt_null;
    end

    assign fifo_pop = packet_enable && (next_type == pkt_audio);

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n || frame_start)
        begin
            acr_sent       <= 1'b0;
            infoframe_sent <= 1'b0;
        end
        else if (packet_enable)
        begin
            if (next_type == pkt_acr)
                acr_sent <= 1'b1;
            if (next_type == pkt_infoframe)
                infoframe_sent <= 1'b1;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out_type  <= pkt_null;
        end
        else
        begin
            out_valid <= packet_enable;
            if (packet_enable)
                out_type <= next_type;
        end
    end

    // head word captured as it is popped
    always_ff @(posedge clk_pixel)
    begin
        if (fifo_pop)
            out_sample <= fifo_data;
    end

    assign packet_out.valid  = out_valid;
    assign packet_out.ptype  = out_type;
    assign packet_out.sample = out_sample;

    a_audio_has_data: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        (packet_out.valid && packet_out.ptype == pkt_audio) |-> $past(fifo_count) != '0);

endmodule

`default_nettype wire

// ==== verilog/console.sv ====
`timescale 1ns/1ps
`default_nettype none

module console (
    input  wire                        clk_pixel,
    input  wire                        rst_n,
    input  wire hdmi_pkg::screen_pos_t pos,
    output hdmi_pkg::rgb_t             rgb
);

    import hdmi_pkg::*;

    logic [7:0] character;
    logic [5:0] prev_row;
    logic [7:0] char_now;
    logic [7:0] attribute;
    logic [2:0] bit_sel;
    logic       glyph_on;
    rgb_t       fg;
    rgb_t       bg;

    // classic 16 colour text palette
    function automatic rgb_t palette(input logic [3:0] idx);
        case (idx)
            4'h0:    palette = 24'h000000;
            4'h1:    palette = 24'h0000aa;
            4'h2:    palette = 24'h00aa00;
            4'h3:    palette = 24'h00aaaa;
            4'h4:    palette = 24'haa0000;
            4'h5:    palette = 24'haa00aa;
            4'h6:    palette = 24'haa5500;
            4'h7:    palette = 24'haaaaaa;
            4'h8:    palette = 24'h555555;
            4'h9:    palette = 24'h5555ff;
            4'ha:    palette = 24'h55ff55;
            4'hb:    palette = 24'h55ffff;
            4'hc:    palette = 24'hff5555;
            4'hd:    palette = 24'hff55ff;
            4'he:    palette = 24'hffff55;
            default: palette = 24'hffffff;
        endcase
    endfunction

    // code for the current text row, valid from its first pixel
    always_comb
    begin
        if (pos.cy == 10'd0)
            char_now = 8'h30;
        else if (prev_row != pos.cy[9:4])
            char_now = character + 8'h01;
        else
            char_now = character;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            character <= 8'h30;
            prev_row  <= '0;
        end
        else
        begin
            character <= char_now;
            prev_row  <= pos.cy[9:4];
        end
    end

    assign attribute = {pos.cx[9], pos.cy[8:6], pos.cx[8:5]};
    assign fg        = palette(attribute[3:0]);
    assign bg        = palette(attribute[7:4]);

    // msb is the leftmost column, bottom 4 lines are spacing
    assign bit_sel  = 3'd7 - pos.cx[2:0];
    assign glyph_on = char_now[bit_sel] && (pos.cy[3:0] < 4'd12);

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
            rgb <= '0;
        else if (!pos.active)
            rgb <= '0; // black in blanking
        else
            rgb <= glyph_on ? fg : bg;
    end

endmodule

`default_nettype wire

// ==== verilog/hdmi_source_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_cfg.svh"

module hdmi_source_top (
    input  wire                    clk_pixel,
    input  wire                    rst_n,
    input  wire  [`AUDIO_BITS-1:0] step,
    output hdmi_pkg::rgb_t         rgb,
    output hdmi_pkg::screen_pos_t  pos,
    output hdmi_pkg::packet_out_t  packet_out,
    output logic                   overflow
);

    logic                             packet_enable;
    logic                             sample_strobe;
    logic [`AUDIO_BITS-1:0]           level;
    logic [`AUDIO_BITS-1:0]           fifo_data;
    logic [$clog2(`FIFO_DEPTH+1)-1:0] fifo_count;
    logic                             fifo_pop;

    video_timing video_timing_inst (
        .clk_pixel     (clk_pixel),
        .rst_n         (rst_n),
        .pos           (pos),
        .packet_enable (packet_enable)
    );

    sawtooth sawtooth_inst (
        .clk_pixel     (clk_pixel),
        .rst_n         (rst_n),
        .step          (step),
        .sample_strobe (sample_strobe),
        .level         (level)
    );

    // single clock stand-in for the audio domain crossing
    audio_fifo #(
        .DEPTH (`FIFO_DEPTH),
        .WIDTH (`AUDIO_BITS)
    ) audio_fifo_inst (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .push      (sample_strobe),
        .wdata     (level),
        .pop       (fifo_pop),
        .rdata     (fifo_data),
        .count     (fifo_count),
        .overflow  (overflow)
    );

    packet_scheduler packet_scheduler_inst (
        .clk_pixel     (clk_pixel),
        .rst_n         (rst_n),
        .pos           (pos),
        .packet_enable (packet_enable),
        .fifo_data     (fifo_data),
        .fifo_count    (fifo_count),
        .fifo_pop      (fifo_pop),
        .packet_out    (packet_out)
    );

    console console_inst (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .pos       (pos),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

// ==== sim/tb_hdmi_source_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_cfg.svh"

module tb_hdmi_source_top;

    import hdmi_pkg::*;

    localparam int ROWS         = 4;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

    logic                   clk_pixel;
    logic                   rst_n;
    logic [`AUDIO_BITS-1:0] step;
    rgb_t                   rgb;
    screen_pos_t            pos;
    packet_out_t            packet_out;
    logic                   overflow;

    // stimulus table, one row per {step, frames}
    logic [`AUDIO_BITS-1:0] step_tbl [ROWS];
    int                     frames_tbl [ROWS];

    rgb_t        palette_tbl [16];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          audio_pkts;
    int          drops;
    int          cycle_count;
    int          cycle_limit;
    logic        running;

    // reference model state for the current cycle
    int                     m_cx;
    int                     m_cy;
    int                     m_div;
    logic                   m_strobe;
    logic [`AUDIO_BITS-1:0] m_level;
    logic [`AUDIO_BITS-1:0] m_fifo [$];
    logic                   m_overflow;
    logic                   acr_sent;
    logic                   info_sent;
    logic                   exp_valid;
    packet_type_e           exp_type;
    logic [`AUDIO_BITS-1:0] exp_sample;
    rgb_t                   exp_rgb;

    hdmi_source_top hdmi_source_top_inst (
        .clk_pixel  (clk_pixel),
        .rst_n      (rst_n),
        .step       (step),
        .rgb        (rgb),
        .pos        (pos),
        .packet_out (packet_out),
        .overflow   (overflow)
    );

    always #20 clk_pixel = ~clk_pixel;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // glyph bits come straight from the code, one code per 16-line row
    function automatic rgb_t pixel_colour(input logic [9:0] cx, input logic [9:0] cy);
        logic [7:0] code;
        logic [7:0] attr;
        logic       lit;
        rgb_t       colour;
        code = 8'h30 + 8'(cy[9:4]);
        attr = {cx[9], cy[8:6], cx[8:5]};
        lit  = code[3'd7 - cx[2:0]] && (cy[3:0] < 4'd12);
        if ((cx >= 10'(`H_ACTIVE)) || (cy >= 10'(`V_ACTIVE)))
            colour = '0;
        else if (lit)
            colour = palette_tbl[attr[3:0]];
        else
            colour = palette_tbl[attr[7:4]];
        return colour;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // compare this cycle, then step the models to the next one
    task automatic advance_model();
        logic full;
        check_value("pos.cx", pos.cx, m_cx);
        check_value("pos.cy", pos.cy, m_cy);
        check_value("pos.active", pos.active, (m_cx < `H_ACTIVE) && (m_cy < `V_ACTIVE));
        check_value("overflow", overflow, m_overflow);
        check_value("rgb", rgb, exp_rgb);
        check_value("packet_out.valid", packet_out.valid, exp_valid);
        if (exp_valid)
        begin
            check_value("packet_out.ptype", packet_out.ptype, exp_type);
            if (exp_type == pkt_audio)
            begin
                audio_pkts++;
                check_value("packet_out.sample", packet_out.sample, exp_sample);
            end
        end

        if (m_cx == 0 && m_cy == 0)
        begin
            acr_sent  = 1'b0;
            info_sent = 1'b0;
        end
        full      = (m_fifo.size() >= `FIFO_DEPTH); // occupancy before this cycle's pop
        exp_valid = (m_cx == `PKT_POS);
        if (exp_valid)
        begin
            if (!acr_sent)
            begin
                exp_type = pkt_acr;
                acr_sent = 1'b1;
            end
            else if (!info_sent)
            begin
                exp_type  = pkt_infoframe;
                info_sent = 1'b1;
            end
            else if (m_fifo.size() != 0)
            begin
                exp_type   = pkt_audio;
                exp_sample = m_fifo.pop_front();
            end
            else
                exp_type = pkt_null;
        end

        if (m_strobe)
        begin
            if (full)
            begin
                m_overflow = 1'b1;
                drops++;
            end
            else
                m_fifo.push_back(m_level);
        end

        exp_rgb = pixel_colour(10'(m_cx), 10'(m_cy));

        // sawtooth, level moves after the strobe cycle
        if (m_strobe)
            m_level = m_level + step;
        m_strobe = (m_div == `SAMPLE_DIV - 1);
        m_div    = (m_div == `SAMPLE_DIV - 1) ? 0 : m_div + 1;

        if (m_cx == `H_TOTAL - 1)
        begin
            m_cx = 0;
            m_cy = (m_cy == `V_TOTAL - 1) ? 0 : m_cy + 1;
        end
        else
            m_cx = m_cx + 1;
    endtask

    always @(negedge clk_pixel)
    begin
        if (running)
            advance_model();
    end

    always @(posedge clk_pixel)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        clk_pixel   = 1'b0;
        rst_n       = 1'b0;
        step        = '0;
        running     = 1'b0;
        errors      = 0;
        checks      = 0;
        audio_pkts  = 0;
        drops       = 0;
        cycle_count = 0;
        m_cx        = 0;
        m_cy        = 0;
        m_div       = 0;
        m_strobe    = 1'b0;
        m_level     = '0;
        m_overflow  = 1'b0;
        acr_sent    = 1'b0;
        info_sent   = 1'b0;
        exp_valid   = 1'b0;
        exp_type    = pkt_null;
        exp_sample  = '0;
        exp_rgb     = '0;

        palette_tbl[0]  = 24'h000000;
        palette_tbl[1]  = 24'h0000aa;
        palette_tbl[2]  = 24'h00aa00;
        palette_tbl[3]  = 24'h00aaaa;
        palette_tbl[4]  = 24'haa0000;
        palette_tbl[5]  = 24'haa00aa;
        palette_tbl[6]  = 24'haa5500;
        palette_tbl[7]  = 24'haaaaaa;
        palette_tbl[8]  = 24'h555555;
        palette_tbl[9]  = 24'h5555ff;
        palette_tbl[10] = 24'h55ff55;
        palette_tbl[11] = 24'h55ffff;
        palette_tbl[12] = 24'hff5555;
        palette_tbl[13] = 24'hff55ff;
        palette_tbl[14] = 24'hffff55;
        palette_tbl[15] = 24'hffffff;

        rng_state     = 32'd94;
        rng_state     = xorshift32(rng_state);
        step_tbl[0]   = 16'h0001;
        frames_tbl[0] = 1;
        step_tbl[1]   = 16'h0100;
        frames_tbl[1] = 1;
        step_tbl[2]   = 16'hffff; // ramps downward
        frames_tbl[2] = 1;
        step_tbl[3]   = rng_state[15:0];
        frames_tbl[3] = 1;

        cycle_limit = 1000;
        for (int r = 0; r < ROWS; r++)
            cycle_limit = cycle_limit + frames_tbl[r] * 420000;

        repeat (2) @(posedge clk_pixel);
        rst_n   <= 1'b1;
        running = 1'b1; // first model cycle is the next negedge

        for (int r = 0; r < ROWS; r++)
        begin
            step <= step_tbl[r];
            repeat (frames_tbl[r] * FRAME_CYCLES) @(posedge clk_pixel);
        end
        running = 1'b0;

        $display("checks %0d, errors %0d, audio packets %0d, dropped samples %0d",
                 checks, errors, audio_pkts, drops);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/hdmi_pkg.sv
verilog/video_timing.sv
verilog/sawtooth.sv
verilog/audio_fifo.sv
verilog/packet_scheduler.sv
verilog/console.sv
verilog/hdmi_source_top.sv
sim/tb_hdmi_source_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP      = tb_hdmi_source_top
FILELIST = list.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) verilog/hdmi_cfg.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
